// ==== csr_defs_pkg.sv ====
`default_nettype none

package csr_defs_pkg;

	typedef logic [31:0] csr_word_t;	// CSR data word

	// Supported CSR addresses
	typedef enum logic [11:0] {
		CSR_FFLAGS        = 12'h001,	// FP exception flags
		CSR_FRM           = 12'h002,	// FP rounding mode
		CSR_FCSR          = 12'h003,	// Flags and rounding mode
		CSR_MSTATUS       = 12'h300,
		CSR_MISA          = 12'h301,
		CSR_MIE           = 12'h304,
		CSR_MTVEC         = 12'h305,
		CSR_MCOUNTINHIBIT = 12'h320,
		CSR_MSCRATCH      = 12'h340,
		CSR_MEPC          = 12'h341,
		CSR_MCAUSE        = 12'h342,
		CSR_MTVAL         = 12'h343,
		CSR_MIP           = 12'h344,
		CSR_MCYCLE        = 12'hB00,
		CSR_MINSTRET      = 12'hB02,
		CSR_MCYCLEH       = 12'hB80,
		CSR_MINSTRETH     = 12'hB82,
		CSR_MVENDORID     = 12'hF11,	// Read-only ID block
		CSR_MARCHID       = 12'hF12,
		CSR_MIMPID        = 12'hF13,
		CSR_MHARTID       = 12'hF14,
		CSR_MCONFIGPTR    = 12'hF15
	} csr_addr_e;

	typedef enum logic [1:0] {
		CSR_OP_WRITE = 2'b01,	// csrrw
		CSR_OP_SET   = 2'b10,	// csrrs
		CSR_OP_CLEAR = 2'b11	// csrrc
	} csr_op_e;

	typedef enum logic [1:0] {
		CNT_CYCLE_LO   = 2'd0,	// mcycle
		CNT_CYCLE_HI   = 2'd1,	// mcycleh
		CNT_INSTRET_LO = 2'd2,	// minstret
		CNT_INSTRET_HI = 2'd3	// minstreth
	} cnt_sel_e;

	localparam int MSTATUS_MIE_BIT  = 3;
	localparam int MSTATUS_MPIE_BIT = 7;
	localparam int MSTATUS_MPP_LO   = 11;	// 2-bit field
	localparam int MSTATUS_FS_LO    = 13;	// 2-bit field
	localparam int MSTATUS_SD_BIT   = 31;

	localparam int MCNTINH_CY_BIT = 0;
	localparam int MCNTINH_IR_BIT = 2;

	localparam int FFLAGS_W = 5;
	localparam int FRM_W    = 3;

	localparam logic [1:0] MISA_MXL_32 = 2'b01;
	localparam int         MISA_F_BIT  = 5;
	localparam int         MISA_I_BIT  = 8;

	localparam csr_word_t MVENDORID_VAL  = 32'h0000_0000;	// Non-commercial
	localparam csr_word_t MARCHID_VAL    = 32'h0000_0000;
	localparam csr_word_t MIMPID_VAL     = 32'h0000_0001;
	localparam csr_word_t MCONFIGPTR_VAL = 32'h0000_0000;
	localparam csr_word_t MTVEC_RST      = 32'h0000_0000;	// Base 0, direct mode

endpackage

`default_nettype wire

// ==== trap_defs_pkg.sv ====
`default_nettype none

package trap_defs_pkg;

	typedef logic [31:0] trap_cause_t;	// mcause layout

	localparam int CAUSE_IRQ_BIT = 31;	// Interrupt flag

	// Synchronous exception codes
	localparam trap_cause_t EXC_INSTR_MISALIGN = 32'd0;
	localparam trap_cause_t EXC_INSTR_FAULT    = 32'd1;
	localparam trap_cause_t EXC_ILLEGAL_INSTR  = 32'd2;
	localparam trap_cause_t EXC_BREAKPOINT     = 32'd3;
	localparam trap_cause_t EXC_LOAD_MISALIGN  = 32'd4;
	localparam trap_cause_t EXC_STORE_MISALIGN = 32'd6;
	localparam trap_cause_t EXC_ECALL_M        = 32'd11;

	localparam int IRQ_MSI = 3;	// Machine software
	localparam int IRQ_MTI = 7;	// Machine timer
	localparam int IRQ_MEI = 11;	// Machine external

	typedef enum logic [1:0] {
		TVEC_DIRECT   = 2'b00,	// All traps to base
		TVEC_VECTORED = 2'b01	// Interrupts to base + 4*code
	} tvec_mode_e;

	// Builds the mcause value of an interrupt
	function automatic trap_cause_t irq_cause(input logic [4:0] num);
		trap_cause_t c;
		c                = '0;
		c[4:0]           = num;
		c[CAUSE_IRQ_BIT] = 1'b1;
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== trap_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface trap_if
	import csr_defs_pkg::*, trap_defs_pkg::*;
(
	input wire clk,
	input wire reset
);

	logic        mie_global;	// mstatus.MIE
	csr_word_t   mie_bits;	// Enable mask
	csr_word_t   mip_bits;	// Pending levels
	csr_word_t   mtvec;
	csr_word_t   mepc;

	logic        trap_take;	// Load trap registers next edge
	trap_cause_t trap_cause;
	csr_word_t   trap_epc;
	csr_word_t   trap_tval;
	logic        mret_take;	// Restore MIE from MPIE

	modport regs (
		input  clk, reset,
		output mie_global, mie_bits, mip_bits, mtvec, mepc,
		input  trap_take, trap_cause, trap_epc, trap_tval, mret_take
	);

	modport ctrl (
		input  clk, reset,
		input  mie_global, mie_bits, mip_bits, mtvec, mepc,
		output trap_take, trap_cause, trap_epc, trap_tval, mret_take
	);

endinterface

`default_nettype wire

// ==== counter_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface counter_if
	import csr_defs_pkg::*;
();

	logic        cnt_wr;	// CSR write to a counter half
	cnt_sel_e    cnt_sel;	// Which half
	csr_word_t   cnt_wdata;
	logic        inhibit_cy;	// mcountinhibit.CY
	logic        inhibit_ir;	// mcountinhibit.IR

	logic [63:0] mcycle;
	logic [63:0] minstret;

	modport regs (
		output cnt_wr, cnt_sel, cnt_wdata, inhibit_cy, inhibit_ir,
		input  mcycle, minstret
	);

	modport cnt (
		input  cnt_wr, cnt_sel, cnt_wdata, inhibit_cy, inhibit_ir,
		output mcycle, minstret
	);

endinterface

`default_nettype wire

// ==== csr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regs
	import csr_defs_pkg::*, trap_defs_pkg::*;
#(
	parameter logic [31:0] HART_ID = 32'h0,
	parameter bit          F_EXT   = 1'b1
)(
	input  wire            clk,
	input  wire            reset,
	input  wire     [11:0] csr_addr,
	input  wire csr_op_e   csr_op,
	input  wire csr_word_t csr_wdata,
	input  wire            csr_wena,
	input  wire            csr_ren,
	input  wire            msip,
	input  wire            mtip,
	input  wire            meip,
	output csr_word_t      csr_rdata,
	output logic           csr_illegal,
	trap_if.regs           tif,
	counter_if.regs        cif
);

	localparam csr_word_t MIE_MASK = (32'd1 << IRQ_MSI) | (32'd1 << IRQ_MTI) |
		(32'd1 << IRQ_MEI);	// Only implemented enables

	logic                mstatus_mie;
	logic                mstatus_mpie;
	csr_word_t           mie_q;
	logic [31:2]         mtvec_base;
	tvec_mode_e          mtvec_mode;
	logic                inh_cy;
	logic                inh_ir;
	csr_word_t           mscratch_q;
	csr_word_t           mepc_q;
	trap_cause_t         mcause_q;
	csr_word_t           mtval_q;
	logic [FFLAGS_W-1:0] fflags_q;
	logic [FRM_W-1:0]    frm_q;

	csr_word_t           mstatus_w;
	csr_word_t           misa_w;
	csr_word_t           mip_w;
	csr_word_t           mtvec_w;
	csr_word_t           fcsr_w;
	csr_word_t           rdata;	// Raw read value
	csr_word_t           wval;	// Value after op
	logic                addr_known;
	logic                access_bad;
	logic                wr_ok;

	// Assembled register views
	always_comb begin
		mstatus_w                          = '0;
		mstatus_w[MSTATUS_MIE_BIT]         = mstatus_mie;
		mstatus_w[MSTATUS_MPIE_BIT]        = mstatus_mpie;
		mstatus_w[MSTATUS_MPP_LO +: 2]     = 2'b11;	// Always M-mode
		mstatus_w[MSTATUS_FS_LO +: 2]      = {2{F_EXT}};	// FP state reported dirty
		mstatus_w[MSTATUS_SD_BIT]          = F_EXT;
		misa_w                             = '0;
		misa_w[31:30]                      = MISA_MXL_32;
		misa_w[MISA_I_BIT]                 = 1'b1;
		misa_w[MISA_F_BIT]                 = F_EXT;
		mip_w                              = '0;
		mip_w[IRQ_MSI]                     = msip;	// Levels straight in
		mip_w[IRQ_MTI]                     = mtip;
		mip_w[IRQ_MEI]                     = meip;
	end

	assign mtvec_w = {mtvec_base, mtvec_mode};
	assign fcsr_w  = csr_word_t'({frm_q, fflags_q});

	// Address decode and read mux
	always_comb begin
		rdata      = '0;
		addr_known = 1'b1;
		case (csr_addr)
			CSR_FFLAGS:        rdata = csr_word_t'(fflags_q);	// View of fcsr
			CSR_FRM:           rdata = csr_word_t'(frm_q);
			CSR_FCSR:          rdata = fcsr_w;
			CSR_MSTATUS:       rdata = mstatus_w;
			CSR_MISA:          rdata = misa_w;
			CSR_MIE:           rdata = mie_q;
			CSR_MTVEC:         rdata = mtvec_w;
			CSR_MCOUNTINHIBIT: rdata = csr_word_t'({inh_ir, 1'b0, inh_cy});
			CSR_MSCRATCH:      rdata = mscratch_q;
			CSR_MEPC:          rdata = mepc_q;
			CSR_MCAUSE:        rdata = mcause_q;
			CSR_MTVAL:         rdata = mtval_q;
			CSR_MIP:           rdata = mip_w;
			CSR_MCYCLE:        rdata = cif.mcycle[31:0];
			CSR_MCYCLEH:       rdata = cif.mcycle[63:32];
			CSR_MINSTRET:      rdata = cif.minstret[31:0];
			CSR_MINSTRETH:     rdata = cif.minstret[63:32];
			CSR_MVENDORID:     rdata = MVENDORID_VAL;
			CSR_MARCHID:       rdata = MARCHID_VAL;
			CSR_MIMPID:        rdata = MIMPID_VAL;
			CSR_MHARTID:       rdata = HART_ID;
			CSR_MCONFIGPTR:    rdata = MCONFIGPTR_VAL;
			default:           addr_known = 1'b0;
		endcase
		if (!F_EXT && (csr_addr inside {CSR_FFLAGS, CSR_FRM, CSR_FCSR})) begin
			addr_known = 1'b0;	// No FP unit
			rdata      = '0;
		end
	end

	// Top two address bits 11 mark read-only space
	assign access_bad  = !addr_known || (csr_wena && (csr_addr[11:10] == 2'b11));
	assign csr_illegal = (csr_ren || csr_wena) && access_bad;
	assign wr_ok       = csr_wena && !access_bad;
	assign csr_rdata   = csr_ren ? rdata : '0;

	always_comb begin
		case (csr_op)
			CSR_OP_SET:   wval = rdata | csr_wdata;
			CSR_OP_CLEAR: wval = rdata & ~csr_wdata;
			default:      wval = csr_wdata;
		endcase
	end

	// Counter halves live in hart_counters
	always_comb begin
		case (csr_addr)
			CSR_MCYCLEH:   cif.cnt_sel = CNT_CYCLE_HI;
			CSR_MINSTRET:  cif.cnt_sel = CNT_INSTRET_LO;
			CSR_MINSTRETH: cif.cnt_sel = CNT_INSTRET_HI;
			default:       cif.cnt_sel = CNT_CYCLE_LO;
		endcase
	end

	assign cif.cnt_wr     = wr_ok &&
		(csr_addr inside {CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH});
	assign cif.cnt_wdata  = wval;
	assign cif.inhibit_cy = inh_cy;
	assign cif.inhibit_ir = inh_ir;

	assign tif.mie_global = mstatus_mie;
	assign tif.mie_bits   = mie_q;
	assign tif.mip_bits   = mip_w;
	assign tif.mtvec      = mtvec_w;
	assign tif.mepc       = mepc_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_q        <= '0;
			mtvec_base   <= MTVEC_RST[31:2];
			mtvec_mode   <= tvec_mode_e'(MTVEC_RST[1:0]);
			inh_cy       <= 1'b0;
			inh_ir       <= 1'b0;
			mscratch_q   <= '0;
			mepc_q       <= '0;
			mcause_q     <= '0;
			mtval_q      <= '0;
			fflags_q     <= '0;
			frm_q        <= '0;
		end else begin
			if (wr_ok) begin
				case (csr_addr)
					CSR_FFLAGS:   fflags_q <= wval[FFLAGS_W-1:0];
					CSR_FRM:      frm_q <= wval[FRM_W-1:0];
					CSR_FCSR: begin
						fflags_q <= wval[FFLAGS_W-1:0];
						frm_q    <= wval[FFLAGS_W +: FRM_W];
					end
					CSR_MSTATUS: begin
						mstatus_mie  <= wval[MSTATUS_MIE_BIT];
						mstatus_mpie <= wval[MSTATUS_MPIE_BIT];
					end
					CSR_MIE:      mie_q <= wval & MIE_MASK;
					CSR_MTVEC: begin
						mtvec_base <= wval[31:2];
						if (wval[1:0] inside {TVEC_DIRECT, TVEC_VECTORED})
							mtvec_mode <= tvec_mode_e'(wval[1:0]);	// Reserved modes keep old
					end
					CSR_MCOUNTINHIBIT: begin
						inh_cy <= wval[MCNTINH_CY_BIT];
						inh_ir <= wval[MCNTINH_IR_BIT];
					end
					CSR_MSCRATCH: mscratch_q <= wval;
					CSR_MEPC:     mepc_q <= {wval[31:2], 2'b00};	// IALIGN 32
					CSR_MCAUSE:   mcause_q <= wval;
					CSR_MTVAL:    mtval_q <= wval;
					default:      ;	// misa, mip writes ignored
				endcase
			end
			if (tif.trap_take) begin	// Trap overrides a same-cycle write
				mepc_q       <= {tif.trap_epc[31:2], 2'b00};
				mcause_q     <= tif.trap_cause;
				mtval_q      <= tif.trap_tval;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
			end else if (tif.mret_take) begin
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end
		end
	end

	a_trap_mret_excl: assert property (@(posedge clk) disable iff (reset)
		!(tif.trap_take && tif.mret_take));

	// Illegal write leaves the CSRs of this block as they were
	a_illegal_no_write: assert property (@(posedge clk) disable iff (reset)
		(csr_wena && csr_illegal && !tif.trap_take && !tif.mret_take)
		|=> $stable({mstatus_w, mie_q, mtvec_w, inh_cy, inh_ir,
			mscratch_q, mepc_q, mcause_q, mtval_q, fcsr_w}));

endmodule

`default_nettype wire

// ==== hart_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_counters
	import csr_defs_pkg::*;
(
	input  wire    clk,
	input  wire    reset,
	input  wire    instr_retire,	// One pulse per retired instruction
	counter_if.cnt cif
);

	logic [63:0] cycle_q;
	logic [63:0] instret_q;
	logic        wr_cy_lo;
	logic        wr_cy_hi;
	logic        wr_ir_lo;
	logic        wr_ir_hi;

	// Write of either half beats the increment
	function automatic logic [63:0] next_count(input logic [63:0] cur, input logic wr_lo,
		input logic wr_hi, input csr_word_t wdata, input logic inc);
		logic [63:0] nxt;
		nxt = cur;
		if (wr_lo)
			nxt[31:0] = wdata;
		else if (wr_hi)
			nxt[63:32] = wdata;
		else if (inc)
			nxt = cur + 64'd1;
		return nxt;
	endfunction

	assign wr_cy_lo = cif.cnt_wr && (cif.cnt_sel == CNT_CYCLE_LO);
	assign wr_cy_hi = cif.cnt_wr && (cif.cnt_sel == CNT_CYCLE_HI);
	assign wr_ir_lo = cif.cnt_wr && (cif.cnt_sel == CNT_INSTRET_LO);
	assign wr_ir_hi = cif.cnt_wr && (cif.cnt_sel == CNT_INSTRET_HI);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle_q   <= '0;
			instret_q <= '0;
		end else begin
			cycle_q   <= next_count(cycle_q, wr_cy_lo, wr_cy_hi, cif.cnt_wdata,
				!cif.inhibit_cy);	// Every edge
			instret_q <= next_count(instret_q, wr_ir_lo, wr_ir_hi, cif.cnt_wdata,
				instr_retire && !cif.inhibit_ir);
		end
	end

	assign cif.mcycle   = cycle_q;
	assign cif.minstret = instret_q;

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
	import csr_defs_pkg::*, trap_defs_pkg::*;
(
	input  wire              exc_valid,
	input  wire trap_cause_t exc_cause,
	input  wire csr_word_t   exc_pc,
	input  wire csr_word_t   exc_tval,
	input  wire              mret,
	input  wire csr_word_t   cur_pc,	// epc for an interrupt
	output logic             redirect_valid,
	output csr_word_t        redirect_pc,
	trap_if.ctrl             tif
);

	csr_word_t  irq_pend;
	logic       irq_any;
	logic       irq_take;
	logic [4:0] irq_num;
	csr_word_t  tvec_base;
	tvec_mode_e tvec_mode;

	assign irq_pend = tif.mie_bits & tif.mip_bits;
	assign irq_any  = irq_pend[IRQ_MEI] || irq_pend[IRQ_MSI] || irq_pend[IRQ_MTI];

	// MEI over MSI over MTI
	always_comb begin
		if (irq_pend[IRQ_MEI])
			irq_num = 5'(IRQ_MEI);
		else if (irq_pend[IRQ_MSI])
			irq_num = 5'(IRQ_MSI);
		else
			irq_num = 5'(IRQ_MTI);
	end

	// Held off by an exception or mret, taken again once MIE is back
	assign irq_take = tif.mie_global && irq_any && !exc_valid && !mret;

	assign tif.trap_take  = exc_valid || irq_take;
	assign tif.trap_cause = exc_valid ? exc_cause : irq_cause(irq_num);
	assign tif.trap_epc   = exc_valid ? exc_pc : cur_pc;
	assign tif.trap_tval  = exc_valid ? exc_tval : '0;	// No tval for interrupts
	assign tif.mret_take  = mret && !exc_valid;

	assign tvec_base = {tif.mtvec[31:2], 2'b00};
	assign tvec_mode = tvec_mode_e'(tif.mtvec[1:0]);

	always_comb begin
		if (tif.trap_take) begin
			redirect_pc = tvec_base;
			if (!exc_valid && (tvec_mode == TVEC_VECTORED))
				redirect_pc = tvec_base + csr_word_t'({irq_num, 2'b00});	// Base + 4*code
		end else begin
			redirect_pc = tif.mepc;	// mret return
		end
	end

	assign redirect_valid = tif.trap_take || tif.mret_take;

	a_redirect_one: assert property (@(posedge tif.clk) disable iff (tif.reset)
		redirect_valid |-> (tif.trap_take ^ tif.mret_take));

	// Register block has captured the epc one cycle later
	a_epc_loaded: assert property (@(posedge tif.clk) disable iff (tif.reset)
		tif.trap_take |=> (tif.mepc == {$past(tif.trap_epc[31:2]), 2'b00}));

endmodule

`default_nettype wire

// ==== csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
	import csr_defs_pkg::*, trap_defs_pkg::*;
#(
	parameter logic [31:0] HART_ID = 32'h0,
	parameter bit          F_EXT   = 1'b1
)(
	input  wire              clk,
	input  wire              reset,
	input  wire       [11:0] csr_addr,
	input  wire csr_op_e     csr_op,
	input  wire csr_word_t   csr_wdata,
	input  wire              csr_wena,
	input  wire              csr_ren,
	output csr_word_t        csr_rdata,
	output logic             csr_illegal,
	input  wire              exc_valid,
	input  wire trap_cause_t exc_cause,
	input  wire csr_word_t   exc_pc,
	input  wire csr_word_t   exc_tval,
	input  wire              mret,
	input  wire              instr_retire,
	input  wire csr_word_t   cur_pc,
	input  wire              msip,
	input  wire              mtip,
	input  wire              meip,
	output logic             redirect_valid,
	output csr_word_t        redirect_pc
);

	trap_if    tif_i (.clk(clk), .reset(reset));
	counter_if cif_i ();

	csr_regs #(
		.HART_ID (HART_ID),
		.F_EXT   (F_EXT)
	) regs_i (
		.clk         (clk),
		.reset       (reset),
		.csr_addr    (csr_addr),
		.csr_op      (csr_op),
		.csr_wdata   (csr_wdata),
		.csr_wena    (csr_wena),
		.csr_ren     (csr_ren),
		.msip        (msip),
		.mtip        (mtip),
		.meip        (meip),
		.csr_rdata   (csr_rdata),
		.csr_illegal (csr_illegal),
		.tif         (tif_i.regs),
		.cif         (cif_i.regs)
	);

	hart_counters cnt_i (
		.clk          (clk),
		.reset        (reset),
		.instr_retire (instr_retire),
		.cif          (cif_i.cnt)
	);

	trap_ctrl ctrl_i (
		.exc_valid      (exc_valid),
		.exc_cause      (exc_cause),
		.exc_pc         (exc_pc),
		.exc_tval       (exc_tval),
		.mret           (mret),
		.cur_pc         (cur_pc),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.tif            (tif_i.ctrl)
	);

endmodule

`default_nettype wire

// ==== csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
	import csr_defs_pkg::*, trap_defs_pkg::*;
();

	localparam int          REC_W     = 6;	// Words per trace record
	localparam int          MAX_RECS  = 128;
	localparam logic [31:0] K_READ    = 32'h00;
	localparam logic [31:0] K_WRITE   = 32'h01;
	localparam logic [31:0] K_RDCAUSE = 32'h02;	// Read checked as mcause
	localparam logic [31:0] K_EXC     = 32'h03;
	localparam logic [31:0] K_MRET    = 32'h04;
	localparam logic [31:0] K_IRQ     = 32'h05;	// Set interrupt levels
	localparam logic [31:0] K_RETIRE  = 32'h06;	// N retire pulses
	localparam logic [31:0] K_END     = 32'hff;

	logic        clk;
	logic        reset;
	logic [11:0] csr_addr;
	csr_op_e     csr_op;
	csr_word_t   csr_wdata;
	logic        csr_wena;
	logic        csr_ren;
	csr_word_t   csr_rdata;
	logic        csr_illegal;
	logic        exc_valid;
	trap_cause_t exc_cause;
	csr_word_t   exc_pc;
	csr_word_t   exc_tval;
	logic        mret;
	logic        instr_retire;
	csr_word_t   cur_pc;
	logic        msip;
	logic        mtip;
	logic        meip;
	logic        redirect_valid;
	csr_word_t   redirect_pc;

	logic [31:0] trace_mem [0:REC_W*MAX_RECS-1];	// Flat record words
	int          n_recs;
	logic        trace_ready;

	csr_unit_top #(
		.HART_ID (32'd5),
		.F_EXT   (1'b1)
	) dut_i (
		.clk            (clk),
		.reset          (reset),
		.csr_addr       (csr_addr),
		.csr_op         (csr_op),
		.csr_wdata      (csr_wdata),
		.csr_wena       (csr_wena),
		.csr_ren        (csr_ren),
		.csr_rdata      (csr_rdata),
		.csr_illegal    (csr_illegal),
		.exc_valid      (exc_valid),
		.exc_cause      (exc_cause),
		.exc_pc         (exc_pc),
		.exc_tval       (exc_tval),
		.mret           (mret),
		.instr_retire   (instr_retire),
		.cur_pc         (cur_pc),
		.msip           (msip),
		.mtip           (mtip),
		.meip           (meip),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string what, input csr_word_t got, input csr_word_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s: got %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_cause(input string what, input trap_cause_t got,
		input trap_cause_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// Drops the strobes and leaves levels and data alone
	task automatic drive_idle();
		csr_wena     = 1'b0;
		csr_ren      = 1'b0;
		exc_valid    = 1'b0;
		mret         = 1'b0;
		instr_retire = 1'b0;
	endtask

	// Drives one trace record on the falling edge and checks it 2 ns later
	task automatic run_record(input int r);
		logic [31:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		kind = trace_mem[r*REC_W];
		a    = trace_mem[r*REC_W+1];
		b    = trace_mem[r*REC_W+2];
		c    = trace_mem[r*REC_W+3];
		d    = trace_mem[r*REC_W+4];
		e    = trace_mem[r*REC_W+5];
		@(negedge clk);
		drive_idle();
		case (kind)
			K_READ, K_RDCAUSE: begin
				csr_addr = a[11:0];
				csr_ren  = 1'b1;
				#2;
				if (kind == K_RDCAUSE)
					check_cause("mcause read", trap_cause_t'(csr_rdata), trap_cause_t'(d));
				else
					check_word("csr read", csr_rdata, d);
				check_flag("csr_illegal on read", csr_illegal, e[0]);
				check_flag("redirect_valid on read", redirect_valid, 1'b0);
			end
			K_WRITE: begin
				csr_addr  = a[11:0];
				csr_op    = csr_op_e'(b[1:0]);
				csr_wdata = c;
				csr_wena  = 1'b1;
				#2;
				check_flag("csr_illegal on write", csr_illegal, e[0]);
				check_flag("redirect_valid on write", redirect_valid, 1'b0);
				check_word("csr_rdata with csr_ren low", csr_rdata, 32'h0);
			end
			K_EXC: begin
				exc_valid = 1'b1;
				exc_cause = a;
				exc_pc    = b;
				exc_tval  = c;
				#2;
				check_flag("redirect_valid on exception", redirect_valid, 1'b1);
				check_word("trap target", redirect_pc, d);
			end
			K_MRET: begin
				mret = 1'b1;
				#2;
				check_flag("redirect_valid on mret", redirect_valid, e[0]);
				if (e[0])
					check_word("mret target", redirect_pc, d);
			end
			K_IRQ: begin
				{meip, mtip, msip} = a[2:0];	// Held until the next level record
				cur_pc             = b;
				#2;
				check_flag("redirect_valid on interrupt", redirect_valid, e[0]);
				if (e[0])
					check_word("interrupt target", redirect_pc, d);
			end
			K_RETIRE: begin
				for (int i = 0; i < int'(a); i++) begin
					if (i > 0)
						@(negedge clk);
					instr_retire = 1'b1;	// Cleared by the next record
				end
			end
			default: begin
				$display("Trace record %0d has an unknown kind %h", r, kind);
				stop_run();
			end
		endcase
	endtask

	// Run limit scales with the trace length
	initial begin
		int limit;
		wait (trace_ready);
		limit = n_recs * 20 + 100;
		repeat (limit) @(posedge clk);
		$display("Timeout: %0d trace records not finished after %0d cycles", n_recs, limit);
		stop_run();
	end

	initial begin
		trace_ready = 1'b0;
		n_recs      = 0;
		reset       = 1'b1;
		drive_idle();
		csr_addr    = '0;
		csr_op      = CSR_OP_WRITE;
		csr_wdata   = '0;
		exc_cause   = '0;
		exc_pc      = '0;
		exc_tval    = '0;
		cur_pc      = '0;
		msip        = 1'b0;
		mtip        = 1'b0;
		meip        = 1'b0;
		$readmemh("csr_unit_trace.txt", trace_mem);
		while (n_recs < MAX_RECS && trace_mem[n_recs*REC_W] !== K_END)
			n_recs++;
		if (n_recs == 0) begin
			$display("The trace file holds no records");
			stop_run();
		end
		trace_ready = 1'b1;
		repeat (4) @(posedge clk);	// Reset for 4 cycles
		@(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < n_recs; r++)
			run_record(r);
		@(negedge clk);
		drive_idle();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== csr_unit_trace.txt ====
// kind arg1 arg2 arg3 expect flag; kinds 0 read, 1 write, 2 mcause read, 3 exception,
// 4 mret, 5 irq levels {meip,mtip,msip}, 6 retire pulses, ff end; ops 1 wr 2 set 3 clr
01 340 1 a5a5f00f 00000000 0
00 340 0 00000000 a5a5f00f 0
01 340 2 0f0f00f0 00000000 0
00 340 0 00000000 afaff0ff 0
01 340 3 ff00000f 00000000 0
00 340 0 00000000 00aff0f0 0
01 305 1 00001000 00000000 0
00 305 0 00000000 00001000 0
01 305 2 00000001 00000000 0
00 305 0 00000000 00001001 0
01 305 3 00000001 00000000 0
00 305 0 00000000 00001000 0
01 f14 1 12345678 00000000 1
00 f14 0 00000000 00000005 0
00 7c0 0 00000000 00000000 1
01 7c0 1 ffffffff 00000000 1
01 f11 1 ffffffff 00000000 1
00 f11 0 00000000 00000000 0
00 301 0 00000000 40000120 0
00 340 0 00000000 00aff0f0 0
01 003 1 000000b3 00000000 0
00 001 0 00000000 00000013 0
00 002 0 00000000 00000005 0
01 002 1 00000002 00000000 0
00 003 0 00000000 00000053 0
01 300 2 00000008 00000000 0
00 300 0 00000000 80007808 0
03 00000002 00000400 deadbeef 00001000 1
00 341 0 00000000 00000400 0
02 342 0 00000000 00000002 0
00 343 0 00000000 deadbeef 0
00 300 0 00000000 80007880 0
04 0 0 00000000 00000400 1
00 300 0 00000000 80007888 0
01 304 1 00000880 00000000 0
01 305 1 00001001 00000000 0
05 6 00000500 00000000 0000102c 1
05 0 00000504 00000000 00000000 0
02 342 0 00000000 8000000b 0
00 341 0 00000000 00000500 0
04 0 0 00000000 00000500 1
05 1 00000600 00000000 00000000 0
00 344 0 00000000 00000008 0
05 0 00000600 00000000 00000000 0
01 320 1 00000005 00000000 0
00 320 0 00000000 00000005 0
01 b00 1 12345678 00000000 0
01 b80 1 0000abcd 00000000 0
00 b00 0 00000000 12345678 0
00 b80 0 00000000 0000abcd 0
01 b02 1 00000010 00000000 0
00 b02 0 00000000 00000010 0
01 320 3 00000004 00000000 0
06 7 0 00000000 00000000 0
00 b02 0 00000000 00000017 0
00 b00 0 00000000 12345678 0
ff 0 0 00000000 00000000 0

// ==== csr_unit.f ====
csr_defs_pkg.sv
trap_defs_pkg.sv
trap_if.sv
counter_if.sv
csr_regs.sv
hart_counters.sv
trap_ctrl.sv
csr_unit_top.sv
csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Done: errors found"

verilator --binary --timing --assert --top-module csr_unit_tb \
	-Mdir obj_dir -f csr_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcsr_unit_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Simulation passed"
exit 0
